// ==== build.f ====
+incdir+dv
hdl/div_cfg_pkg.sv
hdl/div_op_pkg.sv
hdl/div_operand_prep.sv
hdl/divider.sv
hdl/div_result_select.sv
hdl/div_unit.sv
dv/div_unit_tb.sv

// ==== dv/div_unit_checks.svh ====
`ifndef DIV_UNIT_CHECKS_SVH
`define DIV_UNIT_CHECKS_SVH

// expected result by the RISC-V M-extension rules
function automatic xlen_t model_div(div_op_t o, xlen_t a, xlen_t b);
    logic signed [xlen-1:0] sa;
    logic signed [xlen-1:0] sb;
    logic                   overflow;
    xlen_t                  res;
    sa       = a;
    sb       = b;
    overflow = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
    case (o)
        op_div: begin
            if (b == '0) res = '1;
            else if (overflow) res = a;           // most negative by -1
            else res = xlen_t'(sa / sb);         // truncates toward zero
        end
        op_divu: begin
            if (b == '0) res = '1;
            else res = a / b;
        end
        op_rem: begin
            if (b == '0) res = a;
            else if (overflow) res = '0;
            else res = xlen_t'(sa % sb);         // sign follows the dividend
        end
        default: begin
            if (b == '0) res = a;
            else res = a % b;
        end
    endcase
    return res;
endfunction

task automatic check_result(input string what, input xlen_t expected, input xlen_t actual);
    n_checks++;
    if (actual !== expected) begin
        n_errors++;
        $display("FAIL at %0t: result expected %h actual %h (%s)",
                 $time, expected, actual, what);
    end
endtask

task automatic check_latency(input string what, input int expected, input int actual);
    n_checks++;
    if (actual != expected) begin
        n_errors++;
        $display("FAIL at %0t: latency expected %0d actual %0d (%s)",
                 $time, expected, actual, what);
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    n_checks++;
    if (actual !== expected) begin
        n_errors++;
        $display("FAIL at %0t: %s expected %b actual %b", $time, name, expected, actual);
    end
endtask

task automatic check_pulses(input int expected, input int actual);
    n_checks++;
    if (actual != expected) begin
        n_errors++;
        $display("FAIL at %0t: done pulses expected %0d actual %0d", $time, expected, actual);
    end
endtask

`endif

// ==== dv/div_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_unit_tb;
    import div_cfg_pkg::*;
    import div_op_pkg::*;

    localparam int clk_period     = 100;
    localparam int lat_full       = 37;
    localparam int lat_zero       = 4;
    localparam int test_slots     = 16 + 2 + 4 + 2 + 1 + 30;   // one slot per test
    localparam int slot_cycles    = 40;
    localparam int timeout_cycles = test_slots * slot_cycles + 100;
    localparam int wait_limit     = 100;     // per operation

    logic    clk;
    logic    rst_n;
    logic    start;
    div_op_t op;
    xlen_t   dividend;
    xlen_t   divisor;
    xlen_t   result;
    logic    done;
    logic    busy;

    int     n_checks;
    int     n_errors;
    int     cycle_count = 0;
    integer seed;

    `include "div_unit_checks.svh"

    div_unit div_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .result   (result),
        .done     (done),
        .busy     (busy)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: simulation still running after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // one operation, then wait for done and check value and latency
    task automatic run_op(input div_op_t o, input xlen_t a, input xlen_t b);
        int    cycles;
        int    exp_lat;
        xlen_t expected;
        string what;
        expected = model_div(o, a, b);
        exp_lat  = (b == '0) ? lat_zero : lat_full;
        what     = $sformatf("%s %h %h", o.name(), a, b);
        @(posedge clk);
        #1;
        start    = 1'b1;
        op       = o;
        dividend = a;
        divisor  = b;
        @(posedge clk);                     // edge that samples start
        #1;
        start  = 1'b0;
        cycles = 0;
        while (!done && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            n_errors++;
            $display("error at %0t: no done within %0d cycles for %s", $time, wait_limit, what);
        end else begin
            check_result(what, expected, result);
            check_latency(what, exp_lat, cycles);
        end
    endtask

    task automatic signed_ops();
        xlen_t a;
        xlen_t b;
        for (int k = 0; k < 4; k++) begin
            for (int s = 0; s < 4; s++) begin
                a = 32'd7;
                b = 32'd2;
                if (s[0]) a = -a;
                if (s[1]) b = -b;
                run_op(div_op_t'(k[1:0]), a, b);
            end
        end
    endtask

    task automatic unsigned_large();
        run_op(op_divu, 32'hffff_fff0, 32'h8000_0001);
        run_op(op_remu, 32'h8000_0007, 32'h0000_0010);
    endtask

    task automatic zero_divisor();
        for (int k = 0; k < 4; k++) begin
            run_op(div_op_t'(k[1:0]), 32'h8000_1234, 32'h0);
        end
    endtask

    task automatic min_by_minus_one();
        run_op(op_div, 32'h8000_0000, 32'hffff_ffff);
        run_op(op_rem, 32'h8000_0000, 32'hffff_ffff);
    endtask

    // second start lands mid-division and must be dropped
    task automatic start_while_busy();
        int    cycles;
        int    dones;
        int    done_at;
        xlen_t expected;
        expected = model_div(op_div, 32'd1000, 32'd7);
        @(posedge clk);
        #1;
        start    = 1'b1;
        op       = op_div;
        dividend = 32'd1000;
        divisor  = 32'd7;
        @(posedge clk);
        #1;
        start   = 1'b0;
        cycles  = 0;
        dones   = 0;
        done_at = -1;
        repeat (50) begin
            @(posedge clk);
            #1;
            cycles++;
            if (done) begin
                dones++;
                done_at = cycles;
                check_result("first op after dropped start", expected, result);
                check_flag("busy", 1'b1, busy);
            end else if (dones == 1 && cycles == done_at + 1) begin
                check_flag("busy", 1'b0, busy);       // falls on the done edge
            end
            if (cycles == 10) begin
                start    = 1'b1;
                op       = op_rem;
                dividend = 32'd55555;
                divisor  = 32'd13;
            end else begin
                start = 1'b0;
            end
        end
        check_pulses(1, dones);
        check_latency("first op after dropped start", lat_full, done_at);
        check_result("held result", expected, result);
    endtask

    task automatic random_ops();
        xlen_t a;
        xlen_t b;
        xlen_t r_op;
        for (int i = 0; i < 30; i++) begin
            a    = $random(seed);
            b    = $random(seed);
            r_op = $random(seed);
            b    = b >> r_op[6:2];           // spread quotient sizes
            run_op(div_op_t'(r_op[1:0]), a, b);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        op       = op_div;
        dividend = '0;
        divisor  = '0;
        n_checks = 0;
        n_errors = 0;
        seed     = 32'h84b3;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        check_result("after reset", '0, result);

        signed_ops();
        unsigned_large();
        zero_divisor();
        min_by_minus_one();
        start_while_busy();
        random_ops();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/div_cfg_pkg.sv ====
`default_nettype none

package div_cfg_pkg;

    // architectural word
    localparam int xlen = 32;

    // one guard bit so signed and unsigned share one core
    localparam int dlen = xlen + 1;

    // counts up to dlen - 1 iterations
    localparam int cnt_w = 6;

    typedef logic [xlen-1:0] xlen_t;   // operand / result word
    typedef logic [dlen-1:0] dlen_t;   // extended operand / core result

endpackage

`default_nettype wire

// ==== hdl/div_op_pkg.sv ====
`default_nettype none

package div_op_pkg;

    typedef enum logic [1:0] {
        op_div  = 2'd0,
        op_divu = 2'd1,
        op_rem  = 2'd2,
        op_remu = 2'd3
    } div_op_t;

    // zero-extend operands for these
    function automatic logic op_is_unsigned(div_op_t op);
        return (op == op_divu) || (op == op_remu);
    endfunction

    // remainder instead of quotient
    function automatic logic op_is_rem(div_op_t op);
        return (op == op_rem) || (op == op_remu);
    endfunction

endpackage

`default_nettype wire

// ==== hdl/div_operand_prep.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_operand_prep (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  div_op_pkg::div_op_t op,
    input  div_cfg_pkg::xlen_t  dividend,
    input  div_cfg_pkg::xlen_t  divisor,
    input  logic                done,
    output logic                busy,
    output logic                core_start,
    output div_cfg_pkg::dlen_t  core_dividend,
    output div_cfg_pkg::dlen_t  core_divisor,
    output div_op_pkg::div_op_t held_op
);
    import div_cfg_pkg::*;
    import div_op_pkg::*;

    logic  accept;
    logic  sign_ext;
    dlen_t ext_dividend;
    dlen_t ext_divisor;

    assign accept   = start && !busy;       // drop starts while busy
    assign sign_ext = !op_is_unsigned(op);

    // guard bit copies the sign only for signed ops
    assign ext_dividend = {sign_ext & dividend[xlen-1], dividend};
    assign ext_divisor  = {sign_ext & divisor[xlen-1], divisor};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            core_start <= 1'b0;
        end else begin
            core_start <= accept;           // one cycle behind accept
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // held until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            held_op       <= op;
            core_dividend <= ext_dividend;
            core_divisor  <= ext_divisor;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/div_result_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_result_select (
    input  logic                clk,
    input  logic                rst_n,
    input  div_op_pkg::div_op_t held_op,
    input  div_cfg_pkg::dlen_t  div_quotient,
    input  div_cfg_pkg::dlen_t  div_remainder,
    input  logic                div_ready,
    output div_cfg_pkg::xlen_t  result,
    output logic                done
);
    import div_cfg_pkg::*;
    import div_op_pkg::*;

    dlen_t sel;

    assign sel = op_is_rem(held_op) ? div_remainder : div_quotient;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= div_ready;
            if (div_ready) begin
                result <= sel[xlen-1:0];    // drop the guard bit
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/div_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  div_op_pkg::div_op_t op,
    input  div_cfg_pkg::xlen_t  dividend,
    input  div_cfg_pkg::xlen_t  divisor,
    output div_cfg_pkg::xlen_t  result,
    output logic                done,
    output logic                busy
);
    import div_cfg_pkg::*;
    import div_op_pkg::*;

    logic    core_start;
    dlen_t   core_dividend;
    dlen_t   core_divisor;
    div_op_t held_op;
    dlen_t   div_quotient;
    dlen_t   div_remainder;
    logic    div_ready;

    div_operand_prep div_operand_prep_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .op            (op),
        .dividend      (dividend),
        .divisor       (divisor),
        .done          (done),
        .busy          (busy),
        .core_start    (core_start),
        .core_dividend (core_dividend),
        .core_divisor  (core_divisor),
        .held_op       (held_op)
    );

    divider #(
        .WIDTH (dlen)
    ) divider_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .div_s1        (core_dividend),
        .div_s2        (core_divisor),
        .div_start     (core_start),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder),
        .div_ready     (div_ready)
    );

    div_result_select div_result_select_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .held_op       (held_op),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder),
        .div_ready     (div_ready),
        .result        (result),
        .done          (done)
    );

endmodule

`default_nettype wire

// ==== hdl/divider.sv ====
`timescale 1ns/1ns
`default_nettype none

module divider #(
    parameter int WIDTH = div_cfg_pkg::dlen
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] div_s1,          // dividend
    input  logic [WIDTH-1:0] div_s2,          // divisor
    input  logic             div_start,
    output logic [WIDTH-1:0] div_quotient,
    output logic [WIDTH-1:0] div_remainder,
    output logic             div_ready
);
    import div_cfg_pkg::*;

    typedef enum logic [3:0] {
        st_idle = 4'b0001,
        st_calc = 4'b0010,
        st_adj  = 4'b0100,
        st_noop = 4'b1000
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] count;

    logic [WIDTH-1:0] reg_q;                  // dividend shifts out, quotient in
    logic [WIDTH-1:0] reg_r;                  // partial remainder
    logic [WIDTH-1:0] reg_b;                  // divisor magnitude
    logic             r_sign;                 // partial remainder negative

    logic [WIDTH:0]   sub_add;
    logic [WIDTH-1:0] abs_s1;
    logic [WIDTH-1:0] abs_s2;
    logic [WIDTH-1:0] fixed_rem;
    logic             divisor_nz;
    logic             s1_neg;
    logic             s2_neg;
    logic             q_neg;
    logic             r_neg;
    logic             last_step;

    assign divisor_nz = |div_s2;
    assign s1_neg     = div_s1[WIDTH-1];
    assign s2_neg     = div_s2[WIDTH-1];

    assign abs_s1 = s1_neg ? (~div_s1 + 1'b1) : div_s1;
    assign abs_s2 = s2_neg ? (~div_s2 + 1'b1) : div_s2;

    // add back after a negative step, subtract otherwise
    assign sub_add = r_sign ? ({reg_r, reg_q[WIDTH-1]} + {1'b0, reg_b})
                            : ({reg_r, reg_q[WIDTH-1]} - {1'b0, reg_b});

    assign fixed_rem = r_sign ? (reg_r + reg_b) : reg_r;   // final restore

    // zero divisor keeps all ones and the raw dividend
    assign q_neg = (s1_neg ^ s2_neg) && divisor_nz;
    assign r_neg = s1_neg && divisor_nz;

    assign last_step = (count == cnt_w'(WIDTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            count     <= '0;
            div_ready <= 1'b0;
        end else begin
            div_ready <= (state == st_noop);    // results settled one cycle earlier
            case (state)
                st_idle: begin
                    count <= '0;
                    if (div_start) begin
                        state <= divisor_nz ? st_calc : st_adj;
                    end
                end
                st_calc: begin
                    count <= count + 1'b1;
                    if (last_step) begin
                        state <= st_adj;
                    end
                end
                st_adj: begin
                    state <= st_noop;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (div_start) begin
                    reg_q  <= divisor_nz ? abs_s1 : '1;
                    reg_r  <= divisor_nz ? '0 : div_s1;
                    reg_b  <= abs_s2;
                    r_sign <= 1'b0;
                end
            end
            st_calc: begin
                reg_r  <= sub_add[WIDTH-1:0];
                r_sign <= sub_add[WIDTH];
                reg_q  <= {reg_q[WIDTH-2:0], ~sub_add[WIDTH]};  // new quotient bit
            end
            st_adj: begin
                div_quotient  <= q_neg ? (~reg_q + 1'b1) : reg_q;
                div_remainder <= r_neg ? (~fixed_rem + 1'b1) : fixed_rem;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the divide unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module div_unit_tb -o div_unit_sim

output=$(./obj_dir/div_unit_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
else
    exit 1
fi
